//--- Makefile
# Verilator build and run for the smu control-register core testbench
# any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_smu_ctl
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Errors found

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a crashed or stopped simulation also counts as a failure
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
source/smu_ctl_pkg.sv
source/spi_frame_receiver.sv
source/cmd_fifo.sv
source/ctl_register_file.sv
source/spi_steering.sv
source/smu_ctl_top.sv
tb/tb_smu_ctl.sv

//--- source/cmd_fifo.sv
/*
  command queue between the frame receiver and the register file; presents
  its head whenever not empty, pops it in the same cycle and hands one
  credit back to the receiver per pop
*/
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_valid,
  input  smu_ctl_pkg::cmd_t push_cmd,
  output logic              cmd_valid,
  output smu_ctl_pkg::cmd_t cmd,
  output logic              credit_return
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  smu_ctl_pkg::cmd_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              pop;

  // circular wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // head and pop

  // consumer takes every entry, so presenting is popping
  assign cmd_valid     = (count != '0);
  assign pop           = cmd_valid;
  assign cmd           = mem[rd_ptr];
  assign credit_return = pop;

  ////////////////////////////////////////////////////////////
  // storage and pointers

  always_ff @(posedge clk)
  begin
    if (push_valid)
      mem[wr_ptr] <= push_cmd;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(push_valid) - CNT_W'(pop);
    end
  end

  // receiver credits must keep pushes off a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push_valid |-> (count < CNT_W'(FIFO_DEPTH)));

endmodule

//--- source/ctl_register_file.sv
/*
  board control registers; each queued command either updates one 4-bit
  register with the set/clear/toggle rule, reloads the default table on the
  soft-reset address, or is dropped when the address is unknown
*/
`timescale 1ns/1ps

module ctl_register_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  input  smu_ctl_pkg::cmd_t      cmd,
  output smu_ctl_pkg::ctl_regs_t ctl
);

  smu_ctl_pkg::ctl_regs_t ctl_next;

  ////////////////////////////////////////////////////////////
  // address decode and update

  always_comb
  begin
    ctl_next = ctl;
    if (cmd_valid)
    begin
      case (cmd.addr)
        smu_ctl_pkg::ADDR_LED:
        begin
          ctl_next.led = smu_ctl_pkg::apply_update(ctl.led, cmd.set, cmd.clr);
        end
        // mux also drives the chip-select steering
        smu_ctl_pkg::ADDR_MUX:
        begin
          ctl_next.mux = smu_ctl_pkg::apply_update(ctl.mux, cmd.set, cmd.clr);
        end
        smu_ctl_pkg::ADDR_DAC:
        begin
          ctl_next.dac = smu_ctl_pkg::apply_update(ctl.dac, cmd.set, cmd.clr);
        end
        smu_ctl_pkg::ADDR_RAILS:
        begin
          ctl_next.rails = smu_ctl_pkg::apply_update(ctl.rails, cmd.set, cmd.clr);
        end
        // value byte ignored and whole table back to defaults
        smu_ctl_pkg::ADDR_SOFT_RESET:
        begin
          ctl_next = smu_ctl_pkg::CTL_DEFAULTS;
        end
        smu_ctl_pkg::ADDR_CLAMP1:
        begin
          ctl_next.clamp1 = smu_ctl_pkg::apply_update(ctl.clamp1, cmd.set, cmd.clr);
        end
        smu_ctl_pkg::ADDR_RAILS_OE:
        begin
          ctl_next.rails_oe = smu_ctl_pkg::apply_update(ctl.rails_oe, cmd.set, cmd.clr);
        end
        // unknown address holds everything
        default:
        begin
          ctl_next = ctl;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // state

  always_ff @(posedge clk)
  begin
    if (rst)
      ctl <= smu_ctl_pkg::CTL_DEFAULTS;
    else
      ctl <= ctl_next;
  end

endmodule

//--- source/smu_ctl_pkg.sv
/*
  shared widths, register addresses, command and register structs for the
  smu control-register core, plus the set/clear/toggle update rule used by
  the register file and the testbench model
*/

package smu_ctl_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  // one spi frame, address byte then value byte
  localparam int FRAME_BITS  = 16;
  localparam int ADDR_BITS   = 8;
  // control register width, also each half of the value byte
  localparam int NIBBLE_BITS = 4;
  // steered peripherals, one per mux register bit
  localparam int NUM_PERIPH  = 4;

  ////////////////////////////////////////////////////////////
  // register map

  localparam logic [ADDR_BITS-1:0] ADDR_LED        = 8'd7;
  localparam logic [ADDR_BITS-1:0] ADDR_MUX        = 8'd8;
  localparam logic [ADDR_BITS-1:0] ADDR_DAC        = 8'd9;
  localparam logic [ADDR_BITS-1:0] ADDR_RAILS      = 8'd10;
  // write of any value reloads the default table
  localparam logic [ADDR_BITS-1:0] ADDR_SOFT_RESET = 8'd11;
  localparam logic [ADDR_BITS-1:0] ADDR_CLAMP1     = 8'd15;
  localparam logic [ADDR_BITS-1:0] ADDR_RAILS_OE   = 8'd24;

  ////////////////////////////////////////////////////////////
  // structs

  // one decoded write frame, field order matches the wire order
  // high nibble of the value byte clears, low nibble sets
  typedef struct packed {
    logic [ADDR_BITS-1:0]   addr;
    logic [NIBBLE_BITS-1:0] clr;
    logic [NIBBLE_BITS-1:0] set;
  } cmd_t;

  // board control outputs
  typedef struct packed {
    logic [NIBBLE_BITS-1:0] led;
    logic [NIBBLE_BITS-1:0] mux;
    logic [NIBBLE_BITS-1:0] dac;
    logic [NIBBLE_BITS-1:0] rails;
    logic [NIBBLE_BITS-1:0] clamp1;
    logic [NIBBLE_BITS-1:0] rails_oe;
  } ctl_regs_t;

  // clamps are active low, so all ones keeps them off
  // rails_oe bit 0 held high until the rails are brought up
  localparam ctl_regs_t CTL_DEFAULTS = '{
    led:      4'b0000,
    mux:      4'b0000,
    dac:      4'b0000,
    rails:    4'b0000,
    clamp1:   4'b1111,
    rails_oe: 4'b0001
  };

  // shared set and clear bits toggle, everything else holds
  // otherwise set first, then clear
  function automatic logic [NIBBLE_BITS-1:0] apply_update(
    input logic [NIBBLE_BITS-1:0] cur,
    input logic [NIBBLE_BITS-1:0] set,
    input logic [NIBBLE_BITS-1:0] clr
  );
    logic [NIBBLE_BITS-1:0] both;
    both = set & clr;
    if (both != '0)
    begin
      return cur ^ both;
    end
    return (cur | set) & ~clr;
  endfunction

endpackage

//--- source/smu_ctl_top.sv
/*
  top level of the smu control-register core; spi frame receiver feeds the
  command queue under credit flow control, the queue feeds the register
  file, and the mux register steers peripheral chip selects and miso
*/
`timescale 1ns/1ps

module smu_ctl_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               sck,
  input  logic                               cs_n,
  input  logic                               mosi,
  input  logic                               special_n,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_miso,
  output logic                               miso,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output smu_ctl_pkg::ctl_regs_t             ctl
);

  // receiver to queue
  logic              push_valid;
  smu_ctl_pkg::cmd_t push_cmd;
  logic              credit_return;
  // queue to register file
  logic              cmd_valid;
  smu_ctl_pkg::cmd_t cmd;
  // controller data out
  logic              echo_bit;

  ////////////////////////////////////////////////////////////
  // command path

  spi_frame_receiver #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rx (
    .clk(clk),
    .rst(rst),
    .sck(sck),
    .cs_n(cs_n),
    .mosi(mosi),
    .special_n(special_n),
    .credit_return(credit_return),
    .push_valid(push_valid),
    .push_cmd(push_cmd),
    .echo_bit(echo_bit)
  );

  cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk),
    .rst(rst),
    .push_valid(push_valid),
    .push_cmd(push_cmd),
    .cmd_valid(cmd_valid),
    .cmd(cmd),
    .credit_return(credit_return)
  );

  ctl_register_file u_regs (
    .clk(clk),
    .rst(rst),
    .cmd_valid(cmd_valid),
    .cmd(cmd),
    .ctl(ctl)
  );

  ////////////////////////////////////////////////////////////
  // steering, straight from the pins

  spi_steering u_steer (
    .cs_n(cs_n),
    .special_n(special_n),
    .mux(ctl.mux),
    .periph_miso(periph_miso),
    .echo_bit(echo_bit),
    .periph_cs_n(periph_cs_n),
    .miso(miso)
  );

endmodule

//--- source/spi_frame_receiver.sv
/*
  oversamples the spi pins in the clk domain, collects 16-bit frames while
  the controller itself is selected, and pushes each complete frame as a
  command against a credit count; also shifts out the echo of the last frame
*/
`timescale 1ns/1ps

module spi_frame_receiver #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  input  logic              special_n,
  input  logic              credit_return,
  output logic              push_valid,
  output smu_ctl_pkg::cmd_t push_cmd,
  output logic              echo_bit
);

  localparam int FB    = smu_ctl_pkg::FRAME_BITS;
  localparam int CNT_W = $clog2(FB + 2);
  localparam int CRD_W = $clog2(FIFO_DEPTH + 1);
  // count saturates one past a full frame so long frames stay invalid
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(FB + 1);

  // two sync flops plus a third stage only for edge detect
  logic [2:0]        sck_q;
  logic [2:0]        cs_q;
  logic [1:0]        mosi_q;
  logic [1:0]        special_q;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_rise;
  logic              cs_fall;
  logic              sel;
  logic [CNT_W-1:0]  bit_cnt;
  logic [FB-1:0]     frame;
  logic              frame_done;
  logic              pending;
  smu_ctl_pkg::cmd_t pend_cmd;
  logic [CRD_W-1:0]  credits;
  logic [FB-1:0]     last_frame;
  logic [FB-1:0]     echo_sr;

  ////////////////////////////////////////////////////////////
  // synchronizers and edges

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_q     <= '0;
      cs_q      <= '1;
      mosi_q    <= '0;
      special_q <= '1;
    end
    else
    begin
      sck_q     <= {sck_q[1:0], sck};
      cs_q      <= {cs_q[1:0], cs_n};
      mosi_q    <= {mosi_q[0], mosi};
      special_q <= {special_q[0], special_n};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  // controller itself addressed
  assign sel      = ~cs_q[1] & ~special_q[1];

  ////////////////////////////////////////////////////////////
  // bit count and msb-first frame shift

  always_ff @(posedge clk)
  begin
    if (rst || cs_fall || cs_rise)
      bit_cnt <= '0;
    else if (sel && sck_rise && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (sel && sck_rise)
      frame <= {frame[FB-2:0], mosi_q[1]};
  end

  // any other bit count at cs release is dropped
  assign frame_done = cs_rise && (bit_cnt == CNT_W'(FB));

  ////////////////////////////////////////////////////////////
  // credit push where a frame waits in pend_cmd until a credit is held

  assign push_valid = pending && (credits != '0);
  assign push_cmd   = pend_cmd;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending <= 1'b0;
      credits <= CRD_W'(FIFO_DEPTH);
    end
    else
    begin
      if (frame_done)
        pending <= 1'b1;
      else if (push_valid)
        pending <= 1'b0;
      credits <= credits - CRD_W'(push_valid) + CRD_W'(credit_return);
    end
  end

  always_ff @(posedge clk)
  begin
    if (frame_done)
      pend_cmd <= smu_ctl_pkg::cmd_t'(frame);
  end

  ////////////////////////////////////////////////////////////
  // echo of previous complete frame

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      last_frame <= '0;
      echo_sr    <= '0;
    end
    else
    begin
      if (frame_done)
        last_frame <= frame;
      // load at select and shift on falling sck so the master samples on rising
      if (cs_fall && !special_q[1])
        echo_sr <= last_frame;
      else if (sel && sck_fall)
        echo_sr <= {echo_sr[FB-2:0], 1'b0};
    end
  end

  assign echo_bit = echo_sr[FB-1];

  // returned credits never add up past the queue depth
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= CRD_W'(FIFO_DEPTH));

endmodule

//--- source/spi_steering.sv
/*
  combinational spi steering; routes the host chip select to the peripherals
  picked by the mux register and selects miso from them, or from the
  controller echo while the controller itself is addressed
*/
`timescale 1ns/1ps

module spi_steering (
  input  logic                               cs_n,
  input  logic                               special_n,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] mux,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_miso,
  input  logic                               echo_bit,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output logic                               miso
);

  logic [smu_ctl_pkg::NUM_PERIPH-1:0] sel_miso;

  ////////////////////////////////////////////////////////////
  // chip selects

  // controller frames must not reach a peripheral as a spurious write
  always_comb
  begin
    if (!special_n || cs_n)
      periph_cs_n = '1;
    else
      periph_cs_n = ~mux;
  end

  ////////////////////////////////////////////////////////////
  // miso select

  // only the selected peripherals count
  assign sel_miso = mux & periph_miso;

  always_comb
  begin
    if (!special_n)
      miso = echo_bit;
    else
      miso = |sel_miso;
  end

endmodule

//--- tb/tb_smu_ctl.sv
/*
  self-checking testbench for the smu control-register core; an spi master
  sends frames, a register and echo model tracks the expected state, and
  immediate assertions compare the DUT against it after every frame
*/
`timescale 1ns/1ps

module tb_smu_ctl;

  localparam int CLK_PERIOD      = 100;
  localparam int CLKS_PER_FRAME  = 300;
  // frame counts per test summed for the watchdog
  localparam int WRITES_PER_ADDR = 4;
  localparam int UNKNOWN_FRAMES  = 4;
  localparam int BAD_LEN_FRAMES  = 4;
  localparam int TOGGLE_FRAMES   = 6;
  localparam int PRE_RESET_WRITE = 6;
  localparam int ECHO_FRAMES     = 3;
  localparam int NUM_FRAMES      = 6 * WRITES_PER_ADDR + UNKNOWN_FRAMES + BAD_LEN_FRAMES
                                   + TOGGLE_FRAMES + PRE_RESET_WRITE + 1 + 1 + ECHO_FRAMES;

  // board defaults with clamps off (active low) and rails_oe bit 0 high
  localparam smu_ctl_pkg::ctl_regs_t RESET_VALUE = '{
    led:      4'h0,
    mux:      4'h0,
    dac:      4'h0,
    rails:    4'h0,
    clamp1:   4'hF,
    rails_oe: 4'h1
  };

  logic                               clk = 1'b0;
  logic                               rst;
  logic                               sck;
  logic                               cs_n;
  logic                               mosi;
  logic                               special_n;
  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_miso;
  logic                               miso;
  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n;
  smu_ctl_pkg::ctl_regs_t             ctl;

  // expected state
  smu_ctl_pkg::ctl_regs_t model;
  logic [15:0]            last_frame;
  int                     seed = 83012;
  int                     checks = 0;
  int                     errors = 0;
  int                     test_checks;
  int                     test_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  smu_ctl_top #(
    .FIFO_DEPTH(4)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .sck(sck),
    .cs_n(cs_n),
    .mosi(mosi),
    .special_n(special_n),
    .periph_miso(periph_miso),
    .miso(miso),
    .periph_cs_n(periph_cs_n),
    .ctl(ctl)
  );

  ////////////////////////////////////////////////////////////
  // model

  // overlap toggles the shared bits and otherwise sets then clears bit by bit
  function automatic logic [3:0] update_nibble(input logic [3:0] cur, input logic [3:0] s,
                                               input logic [3:0] c);
    logic [3:0] res;
    logic       overlap;
    res = cur;
    overlap = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if (s[i] && c[i])
        overlap = 1'b1;
    end
    for (int i = 0; i < 4; i++)
    begin
      if (overlap)
      begin
        if (s[i] && c[i])
          res[i] = ~cur[i];
      end
      else
      begin
        if (s[i])
          res[i] = 1'b1;
        if (c[i])
          res[i] = 1'b0;
      end
    end
    return res;
  endfunction

  // high when any peripheral picked by the mux drives its miso high
  function automatic logic any_selected_high(input logic [3:0] m, input logic [3:0] pm);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if (m[i] && pm[i])
        hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic is_known(input logic [7:0] a);
    return a inside {8'd7, 8'd8, 8'd9, 8'd10, 8'd11, 8'd15, 8'd24};
  endfunction

  // six register addresses without the soft reset
  function automatic logic [7:0] kept_address(input logic [2:0] k);
    case (k)
      3'd0: return 8'd7;
      3'd1: return 8'd8;
      3'd2: return 8'd9;
      3'd3: return 8'd10;
      3'd4: return 8'd15;
      default: return 8'd24;
    endcase
  endfunction

  task automatic model_frame(input logic [15:0] f);
    logic [3:0] s;
    logic [3:0] c;
    s = f[3:0];
    c = f[7:4];
    case (f[15:8])
      8'd7:  model.led      = update_nibble(model.led, s, c);
      8'd8:  model.mux      = update_nibble(model.mux, s, c);
      8'd9:  model.dac      = update_nibble(model.dac, s, c);
      8'd10: model.rails    = update_nibble(model.rails, s, c);
      8'd11: model          = RESET_VALUE;
      8'd15: model.clamp1   = update_nibble(model.clamp1, s, c);
      8'd24: model.rails_oe = update_nibble(model.rails_oe, s, c);
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // checking and reporting

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d failed", num, name,
             checks - test_checks, errors - test_errors);
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // mode 0 spi master sending msb first with sck at 1/8 of clk

  task automatic send_frame(input logic [31:0] bits, input int nbits);
    logic [31:0] tx;
    logic [15:0] echo;
    tx = bits << (32 - nbits);
    echo = last_frame;
    @(negedge clk);
    special_n = 1'b0;
    cs_n = 1'b0;
    repeat (nbits)
    begin
      mosi = tx[31];
      tx = tx << 1;
      wait_clocks(4);
      // echo sampled just before the rising edge and zero past bit 16
      check_value("miso", 32'(miso), 32'(echo[15]));
      echo = echo << 1;
      sck = 1'b1;
      wait_clocks(4);
      sck = 1'b0;
    end
    wait_clocks(4);
    cs_n = 1'b1;
    special_n = 1'b1;
    // only whole frames reach the registers or the echo
    if (nbits == 16)
    begin
      last_frame = bits[15:0];
      model_frame(bits[15:0]);
    end
    wait_clocks(16);
    check_value("ctl", 32'(ctl), 32'(model));
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  initial
  begin
    logic [31:0] r;
    logic [15:0] f;
    logic [3:0]  sh;
    logic [3:0]  p;
    logic [3:0]  exp_cs;
    rst = 1'b1;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    special_n = 1'b1;
    periph_miso = '0;
    model = RESET_VALUE;
    last_frame = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    wait_clocks(2);

    begin_test();
    check_value("ctl", 32'(ctl), 32'(RESET_VALUE));
    check_value("periph_cs_n", 32'(periph_cs_n), 32'hF);
    end_test(1, "reset defaults");

    // non-overlapping writes then frames that must be ignored
    begin_test();
    for (int k = 0; k < 6; k++)
    begin
      repeat (WRITES_PER_ADDR)
      begin
        r = $random(seed);
        send_frame(32'({kept_address(3'(k)), r[7:4] & ~r[3:0], r[3:0]}), 16);
      end
    end
    repeat (UNKNOWN_FRAMES)
    begin
      do
      begin
        r = $random(seed);
      end
      while (is_known(r[15:8]));
      send_frame(32'(r[15:0]), 16);
    end
    repeat (BAD_LEN_FRAMES / 2)
    begin
      r = $random(seed);
      f = {kept_address(3'(r[31:16] % 16'd6)), r[7:4] & ~r[3:0], r[3:0]};
      send_frame({17'h0, f[15:1]}, 15);
      send_frame({15'h0, 1'b1, f}, 17);
    end
    end_test(2, "set/clear writes");

    begin_test();
    for (int k = 0; k < TOGGLE_FRAMES; k++)
    begin
      r = $random(seed);
      sh = (r[11:8] == 4'h0) ? 4'h8 : r[11:8];
      send_frame(32'({kept_address(3'(k)), r[7:4] | sh, r[3:0] | sh}), 16);
    end
    end_test(3, "overlap toggles");

    begin_test();
    repeat (PRE_RESET_WRITE)
    begin
      r = $random(seed);
      send_frame(32'({kept_address(3'(r[31:16] % 16'd6)), r[11:8] & ~r[3:0], r[3:0]}), 16);
    end
    r = $random(seed);
    send_frame(32'({8'd11, r[7:0]}), 16);
    check_value("ctl", 32'(ctl), 32'(RESET_VALUE));
    end_test(4, "soft reset");

    // mux loaded with a known nonzero pattern whose clear nibble is its complement
    begin_test();
    r = $random(seed);
    p = (r[3:0] == 4'h0) ? 4'h5 : r[3:0];
    send_frame(32'({8'd8, ~p, p}), 16);
    check_value("ctl.mux", 32'(ctl.mux), 32'(p));
    @(negedge clk);
    special_n = 1'b1;
    cs_n = 1'b0;
    repeat (4)
    begin
      r = $random(seed);
      periph_miso = r[3:0];
      @(posedge clk);
      exp_cs = ~model.mux;
      check_value("periph_cs_n", 32'(periph_cs_n), 32'(exp_cs));
      check_value("miso", 32'(miso), 32'(any_selected_high(model.mux, periph_miso)));
      @(negedge clk);
    end
    cs_n = 1'b1;
    @(posedge clk);
    check_value("periph_cs_n", 32'(periph_cs_n), 32'hF);
    @(negedge clk);
    special_n = 1'b0;
    cs_n = 1'b0;
    @(posedge clk);
    check_value("periph_cs_n", 32'(periph_cs_n), 32'hF);
    @(negedge clk);
    cs_n = 1'b1;
    special_n = 1'b1;
    wait_clocks(8);
    end_test(5, "steering");

    // unknown addresses so only the echo moves
    begin_test();
    send_frame(32'h0000_A55A, 16);
    send_frame(32'h0000_C33C, 16);
    send_frame(32'h0000_5AA5, 16);
    end_test(6, "echo");

    $display("total checks %0d, failed %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // a hung handshake ends the run here
  initial
  begin
    #(NUM_FRAMES * CLKS_PER_FRAME * CLK_PERIOD);
    $display("watchdog timeout after %0d clock periods", NUM_FRAMES * CLKS_PER_FRAME);
    $display("Errors found");
    $finish;
  end

endmodule
